// ==== common/l2_cfg.svh ====
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// set index width, 4 bits gives 16 sets
`define L2_SET_BITS 4

// byte address width on both ports
`define L2_ADDR_BITS 32

// 256-bit lines, so 32 bytes per line
`define L2_OFFSET_BITS 5

`define L2_TAG_BITS (`L2_ADDR_BITS - `L2_SET_BITS - `L2_OFFSET_BITS)

`endif

// ==== common/l2_pkg.sv ====
`include "l2_cfg.svh"

package l2_pkg;

    typedef logic [255:0] line_t;

    typedef logic [1:0] l2_way_t;   // four ways, fixed by the plru tree

    typedef struct packed {
        logic [`L2_TAG_BITS-1:0]    tag;
        logic [`L2_SET_BITS-1:0]    set;
        logic [`L2_OFFSET_BITS-1:0] offset;
    } l2_addr_fields_t;

    // same address word seen raw or split into fields
    typedef union packed {
        logic [`L2_ADDR_BITS-1:0] raw;
        l2_addr_fields_t          f;
    } l2_addr_u;

    typedef struct packed {
        logic                    dirty;
        logic [`L2_TAG_BITS-1:0] tag;
    } l2_tag_t;

    typedef enum logic [2:0] {
        idle,
        compare,
        write_back,
        allocate,
        refill_wait,
        flush_check,
        flush_write
    } l2_state_e;

endpackage

// ==== common/l2_array_if.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

// array access between l2_ctrl and l2_ways; set_idx follows l2_state_e
// (walker set in flush_check/flush_write, request set otherwise)
interface l2_array_if;
    import l2_pkg::*;

    logic [`L2_SET_BITS-1:0] set_idx;
    l2_way_t                 wr_way;
    logic                    data_we;
    logic                    tag_we;
    logic                    valid_we;
    logic                    valid_clr;   // drops every valid bit at once
    line_t                   data_in;
    l2_tag_t                 tag_in;      // tag field doubles as the lookup tag

    logic                    hit;
    l2_way_t                 hit_way;
    line_t                   hit_data;
    l2_tag_t [3:0]           way_tag;
    logic [3:0]              way_valid;
    line_t [3:0]             way_data;

    modport ctrl (
        output set_idx, wr_way, data_we, tag_we, valid_we, valid_clr, data_in, tag_in,
        input  hit, hit_way, hit_data, way_tag, way_valid, way_data
    );

    modport ways (
        input  set_idx, wr_way, data_we, tag_we, valid_we, valid_clr, data_in, tag_in,
        output hit, hit_way, hit_data, way_tag, way_valid, way_data
    );

endinterface

// ==== logic/flush_walker.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module flush_walker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    step,
    output logic [`L2_SET_BITS-1:0] walk_set,
    output l2_pkg::l2_way_t         walk_way,
    output logic                    last
);
    import l2_pkg::*;

    logic [`L2_SET_BITS+1:0] slot;   // set in the upper bits, way in the low two

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (start) begin
            slot <= '0;
        end else if (step) begin
            slot <= slot + 1'b1;
        end
    end

    assign walk_set = slot[`L2_SET_BITS+1:2];
    assign walk_way = l2_way_t'(slot[1:0]);
    assign last     = &slot;

endmodule

// ==== l2cache/l2_plru.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_plru (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`L2_SET_BITS-1:0] set_idx,
    input  logic                    touch,
    input  l2_pkg::l2_way_t         touch_way,
    input  logic                    clear,
    output l2_pkg::l2_way_t         victim_way
);
    import l2_pkg::*;

    localparam int num_sets = 1 << `L2_SET_BITS;

    logic [2:0] tree [num_sets];   // [2] root, [1] pair 0/1, [0] pair 2/3
    logic [2:0] cur;
    logic [2:0] upd;

    assign cur = tree[set_idx];

    always_comb begin
        unique case (touch_way)
            2'd0:    upd = {1'b1, 1'b1, cur[0]};
            2'd1:    upd = {1'b1, 1'b0, cur[0]};
            2'd2:    upd = {1'b0, cur[1], 1'b1};
            default: upd = {1'b0, cur[1], 1'b0};
        endcase
    end

    // root picks the pair, pair bit picks the way
    assign victim_way = cur[2] ? (cur[0] ? 2'd3 : 2'd2) : (cur[1] ? 2'd1 : 2'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) tree[s] <= '0;
        end else if (clear) begin
            for (int s = 0; s < num_sets; s++) tree[s] <= '0;
        end else if (touch) begin
            tree[set_idx] <= upd;
        end
    end

endmodule

// ==== l2cache/l2_ways.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_ways (
    input  logic     clk,
    input  logic     rst_n,
    l2_array_if.ways arr
);
    import l2_pkg::*;

    localparam int num_sets = 1 << `L2_SET_BITS;

    l2_tag_t    tag_mem   [num_sets][4];   // dirty bit lives with the tag
    logic [3:0] valid_mem [num_sets];
    line_t      data_mem  [num_sets][4];
    logic [3:0] way_hits;

    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < 4; w++) begin
            arr.way_tag[w]   = tag_mem[arr.set_idx][w];
            arr.way_valid[w] = valid_mem[arr.set_idx][w];
            arr.way_data[w]  = data_mem[arr.set_idx][w];
            way_hits[w]      = arr.way_valid[w] && (arr.way_tag[w].tag == arr.tag_in.tag);
        end
        for (int w = 3; w >= 0; w--) begin
            if (way_hits[w]) arr.hit_way = l2_way_t'(w);
        end
        arr.hit      = |way_hits;
        arr.hit_data = arr.way_data[arr.hit_way];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[s] <= '0;
                for (int w = 0; w < 4; w++) begin
                    tag_mem[s][w] <= '0;
                end
            end
        end else begin
            if (arr.valid_clr) begin
                for (int s = 0; s < num_sets; s++) begin
                    valid_mem[s] <= '0;
                end
            end else if (arr.valid_we) begin
                valid_mem[arr.set_idx][arr.wr_way] <= 1'b1;
            end
            if (arr.tag_we) begin
                tag_mem[arr.set_idx][arr.wr_way] <= arr.tag_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.data_we) begin
            data_mem[arr.set_idx][arr.wr_way] <= arr.data_in;
        end
    end

    // a refill never duplicates a tag already resident in the set
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hits));

endmodule

// ==== l2cache/l2_ctrl.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`L2_ADDR_BITS-1:0] ufp_addr,
    input  logic                     ufp_read,
    input  logic                     ufp_write,
    input  l2_pkg::line_t            ufp_wdata,
    output l2_pkg::line_t            ufp_rdata,
    output logic                     ufp_resp,
    input  logic                     flush,
    output logic                     flush_done,
    output logic [`L2_ADDR_BITS-1:0] dfp_addr,
    output logic                     dfp_read,
    output logic                     dfp_write,
    output l2_pkg::line_t            dfp_wdata,
    input  l2_pkg::line_t            dfp_rdata,
    input  logic                     dfp_resp,
    l2_array_if.ctrl                 arr,
    input  l2_pkg::l2_way_t          victim_way,
    output logic                     plru_touch,
    output l2_pkg::l2_way_t          plru_touch_way,
    output logic                     plru_clear,
    output logic                     walk_start,
    output logic                     walk_step,
    input  logic [`L2_SET_BITS-1:0]  walk_set,
    input  l2_pkg::l2_way_t          walk_way,
    input  logic                     walk_last
);
    import l2_pkg::*;

    l2_state_e state, state_next;
    l2_addr_u  req_addr;
    l2_addr_u  fill_addr;
    l2_addr_u  wb_addr;
    l2_way_t   slot_way;     // way under work, victim or walker slot
    logic      in_flush;
    logic      slot_dirty;
    logic      advance;      // walker slot finished

    assign in_flush   = (state == flush_check) || (state == flush_write);
    assign slot_way   = in_flush ? walk_way : victim_way;
    assign slot_dirty = arr.way_valid[slot_way] && arr.way_tag[slot_way].dirty;
    assign arr.set_idx = in_flush ? walk_set : req_addr.f.set;

    always_comb begin
        req_addr.raw        = ufp_addr;
        fill_addr.raw       = ufp_addr;
        fill_addr.f.offset  = '0;                         // line aligned refill
        wb_addr.f.tag       = arr.way_tag[slot_way].tag;  // rebuilt from stored tag
        wb_addr.f.set       = arr.set_idx;
        wb_addr.f.offset    = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next       = state;
        advance          = 1'b0;
        arr.wr_way       = slot_way;
        arr.data_we      = 1'b0;
        arr.tag_we       = 1'b0;
        arr.valid_we     = 1'b0;
        arr.valid_clr    = 1'b0;
        arr.data_in      = dfp_rdata;
        arr.tag_in.dirty = 1'b0;
        arr.tag_in.tag   = req_addr.f.tag;
        ufp_resp         = 1'b0;
        ufp_rdata        = arr.hit_data;
        flush_done       = 1'b0;
        dfp_read         = 1'b0;
        dfp_write        = 1'b0;
        dfp_addr         = wb_addr.raw;
        dfp_wdata        = arr.way_data[slot_way];
        plru_touch       = 1'b0;
        plru_touch_way   = arr.hit_way;
        plru_clear       = 1'b0;
        walk_start       = 1'b0;
        walk_step        = 1'b0;

        unique case (state)
            idle: begin
                if (flush) begin                  // flush wins over an access
                    walk_start = 1'b1;
                    state_next = flush_check;
                end else if (ufp_read || ufp_write) begin
                    state_next = compare;
                end
            end
            compare: begin
                if (arr.hit) begin
                    ufp_resp   = 1'b1;
                    plru_touch = 1'b1;
                    arr.wr_way = arr.hit_way;
                    if (ufp_write) begin
                        arr.data_in      = ufp_wdata;
                        arr.data_we      = 1'b1;
                        arr.tag_in.dirty = 1'b1;
                        arr.tag_we       = 1'b1;
                    end
                    state_next = idle;
                end else if (slot_dirty) begin
                    state_next = write_back;
                end else begin
                    state_next = allocate;
                end
            end
            write_back: begin
                dfp_write = 1'b1;
                if (dfp_resp) state_next = allocate;
            end
            allocate: begin
                dfp_read = 1'b1;
                dfp_addr = fill_addr.raw;
                if (dfp_resp) begin
                    arr.data_we  = 1'b1;           // refilled line is clean
                    arr.tag_we   = 1'b1;
                    arr.valid_we = 1'b1;
                    state_next   = refill_wait;
                end
            end
            refill_wait: state_next = compare;   // arrays settle, then hit
            flush_check: begin
                if (slot_dirty) state_next = flush_write;
                else            advance    = 1'b1;
            end
            flush_write: begin
                dfp_write = 1'b1;
                if (dfp_resp) begin
                    arr.tag_in.tag = arr.way_tag[slot_way].tag;
                    arr.tag_we     = 1'b1;         // mark the slot clean
                    advance        = 1'b1;
                end
            end
            default: state_next = idle;
        endcase

        if (advance) begin
            if (walk_last) begin
                arr.valid_clr = 1'b1;
                plru_clear    = 1'b1;
                flush_done    = 1'b1;
                state_next    = idle;
            end else begin
                walk_step  = 1'b1;
                state_next = flush_check;
            end
        end
    end

    // a downward request keeps its address until memory answers
    a_dfp_held: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_read || dfp_write) && !dfp_resp |=>
            $stable(dfp_addr) && $stable(dfp_read) && $stable(dfp_write));

    // the requester is answered only while it still asks
    a_resp_to_request: assert property (@(posedge clk) disable iff (!rst_n)
        ufp_resp |-> ufp_read || ufp_write);

endmodule

// ==== l2cache/l2_top.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`L2_ADDR_BITS-1:0] ufp_addr,
    input  logic                     ufp_read,
    input  logic                     ufp_write,
    input  logic [255:0]             ufp_wdata,
    output logic [255:0]             ufp_rdata,
    output logic                     ufp_resp,
    input  logic                     flush,
    output logic                     flush_done,
    output logic [`L2_ADDR_BITS-1:0] dfp_addr,
    output logic                     dfp_read,
    output logic                     dfp_write,
    output logic [255:0]             dfp_wdata,
    input  logic [255:0]             dfp_rdata,
    input  logic                     dfp_resp
);
    import l2_pkg::*;

    l2_way_t                 victim_way;
    l2_way_t                 touch_way;
    l2_way_t                 walk_way;
    logic [`L2_SET_BITS-1:0] walk_set;
    logic                    plru_touch;
    logic                    plru_clear;
    logic                    walk_start;
    logic                    walk_step;
    logic                    walk_last;

    l2_array_if arr ();

    l2_ctrl ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ufp_addr       (ufp_addr),
        .ufp_read       (ufp_read),
        .ufp_write      (ufp_write),
        .ufp_wdata      (ufp_wdata),
        .ufp_rdata      (ufp_rdata),
        .ufp_resp       (ufp_resp),
        .flush          (flush),
        .flush_done     (flush_done),
        .dfp_addr       (dfp_addr),
        .dfp_read       (dfp_read),
        .dfp_write      (dfp_write),
        .dfp_wdata      (dfp_wdata),
        .dfp_rdata      (dfp_rdata),
        .dfp_resp       (dfp_resp),
        .arr            (arr.ctrl),
        .victim_way     (victim_way),
        .plru_touch     (plru_touch),
        .plru_touch_way (touch_way),
        .plru_clear     (plru_clear),
        .walk_start     (walk_start),
        .walk_step      (walk_step),
        .walk_set       (walk_set),
        .walk_way       (walk_way),
        .walk_last      (walk_last)
    );

    l2_ways ways_i (
        .clk   (clk),
        .rst_n (rst_n),
        .arr   (arr.ways)
    );

    l2_plru plru_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_idx    (arr.set_idx),
        .touch      (plru_touch),
        .touch_way  (touch_way),
        .clear      (plru_clear),
        .victim_way (victim_way)
    );

    flush_walker walker_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (walk_start),
        .step     (walk_step),
        .walk_set (walk_set),
        .walk_way (walk_way),
        .last     (walk_last)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end
endmodule

// ==== tb/l2_mem_model.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_mem_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`L2_ADDR_BITS-1:0] dfp_addr,
    input  logic                     dfp_read,
    input  logic                     dfp_write,
    input  logic [255:0]             dfp_wdata,
    output logic [255:0]             dfp_rdata,
    output logic                     dfp_resp,
    input  logic [2:0]               delay       // cycles to dfp_resp, 1 to 4
);
    import l2_pkg::*;

    line_t mem [64];   // 8 tags by 8 sets, loaded from the testbench
    logic  pending;
    int    wait_left;

    // low three tag bits and low three set bits pick the line
    function automatic int slot_of(input logic [`L2_ADDR_BITS-1:0] a);
        return {a[`L2_SET_BITS+`L2_OFFSET_BITS +: 3], a[`L2_OFFSET_BITS +: 3]};
    endfunction

    initial begin
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        pending   = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (dfp_resp || !rst_n || !(dfp_read || dfp_write)) begin
                dfp_resp = 1'b0;   // one cycle pulse
                pending  = 1'b0;
            end else begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = delay;
                end
                if (wait_left <= 1) begin
                    if (dfp_write) mem[slot_of(dfp_addr)] = dfp_wdata;
                    else           dfp_rdata = mem[slot_of(dfp_addr)];
                    dfp_resp = 1'b1;
                    pending  = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end
endmodule

// ==== tb/l2_tb.sv ====
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_tb;
    import l2_pkg::*;

    logic                     clk;
    logic                     rst_n;
    logic [`L2_ADDR_BITS-1:0] ufp_addr;
    logic                     ufp_read;
    logic                     ufp_write;
    line_t                    ufp_wdata;
    line_t                    ufp_rdata;
    logic                     ufp_resp;
    logic                     flush;
    logic                     flush_done;
    logic [`L2_ADDR_BITS-1:0] dfp_addr;
    logic                     dfp_read;
    logic                     dfp_write;
    line_t                    dfp_wdata;
    line_t                    dfp_rdata;
    logic                     dfp_resp;
    logic [2:0]               mem_delay;

    logic [15:0] lfsr;
    int          errors;
    int          read_count;
    int          write_count;
    logic [31:0] last_read_addr;
    logic [31:0] last_write_addr;
    logic        in_flush;
    logic [63:0] written;      // golden holds a value for this line
    logic [63:0] flushed;
    line_t       golden [64];
    logic [2:0]  m_tree;       // expected plru tree of set 7
    logic [2:0]  m_tag [4];
    logic [3:0]  m_valid;

    tb_clk_gen clk_i (.clk(clk), .rst_n(rst_n));

    l2_mem_model mem_i (
        .clk(clk), .rst_n(rst_n), .dfp_addr(dfp_addr), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .dfp_wdata(dfp_wdata), .dfp_rdata(dfp_rdata),
        .dfp_resp(dfp_resp), .delay(mem_delay)
    );

    l2_top dut_i (
        .clk(clk), .rst_n(rst_n), .ufp_addr(ufp_addr), .ufp_read(ufp_read),
        .ufp_write(ufp_write), .ufp_wdata(ufp_wdata), .ufp_rdata(ufp_rdata),
        .ufp_resp(ufp_resp), .flush(flush), .flush_done(flush_done),
        .dfp_addr(dfp_addr), .dfp_read(dfp_read), .dfp_write(dfp_write),
        .dfp_wdata(dfp_wdata), .dfp_rdata(dfp_rdata), .dfp_resp(dfp_resp)
    );

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = rand_bits(32);
        end
        return l;
    endfunction

    function automatic logic [31:0] line_addr(input int tag, input int set);
        return (32'(tag) << (`L2_SET_BITS + `L2_OFFSET_BITS)) | (32'(set) << `L2_OFFSET_BITS);
    endfunction

    function automatic int line_index(input logic [31:0] a);
        return {a[`L2_SET_BITS+`L2_OFFSET_BITS +: 3], a[`L2_OFFSET_BITS +: 3]};
    endfunction

    // initial memory contents, odd multiplier so every address bit counts
    function automatic line_t fill_line(input logic [31:0] a);
        line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = a * 32'h9e37_79b1 + k * 32'h0101_0101;
        end
        return l;
    endfunction

    // expected line: last write, else the initial pattern
    function automatic line_t ref_line(input logic [31:0] a);
        logic [31:0] la;
        la = {a[31:5], 5'b0};
        if (written[line_index(la)]) return golden[line_index(la)];
        return fill_line(la);
    endfunction

    function automatic l2_way_t tree_victim(input logic [2:0] t);
        if (t[2]) return t[0] ? 2'd3 : 2'd2;   // root set, pair 2/3
        return t[1] ? 2'd1 : 2'd0;
    endfunction

    // point the tree away from the touched way
    function automatic logic [2:0] tree_touch(input logic [2:0] t, input l2_way_t w);
        logic [2:0] n;
        n    = t;
        n[2] = ~w[1];
        if (w[1]) n[0] = ~w[0];
        else      n[1] = ~w[0];
        return n;
    endfunction

    task automatic stop_run(input string why);
        errors++;
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic track(input int tag);
        int hw;
        hw = -1;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[w] && m_tag[w] == tag) hw = w;
        end
        if (hw < 0) begin                // miss fills the plru victim
            hw          = tree_victim(m_tree);
            m_tag[hw]   = 3'(tag);
            m_valid[hw] = 1'b1;
        end
        m_tree = tree_touch(m_tree, l2_way_t'(hw));
    endtask

    task automatic access(input logic write, input logic [31:0] addr, input line_t data);
        int n;
        ufp_addr  = addr;
        ufp_read  = !write;
        ufp_write = write;
        ufp_wdata = data;
        n = 0;
        @(negedge clk);
        while (!ufp_resp) begin
            n++;
            if (n > 100) stop_run($sformatf("ufp_resp never came for address %h", addr));
            @(negedge clk);
        end
        if (write) begin
            golden[line_index(addr)]  = data;
            written[line_index(addr)] = 1'b1;
        end
        @(posedge clk);
        #1;
        ufp_read  = 1'b0;
        ufp_write = 1'b0;
    endtask

    task automatic run_flush();
        int n;
        flushed  = '0;
        in_flush = 1'b1;
        flush    = 1'b1;
        n = 0;
        @(negedge clk);
        while (!flush_done) begin
            n++;
            if (n > 2000) stop_run("flush_done never came after a flush request");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        check_equal("flush_done", flush_done, 1'b0);   // one cycle pulse
        flush    = 1'b0;
        in_flush = 1'b0;
    endtask

    // compare process, sampling mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (ufp_resp && ufp_read) check_equal("ufp_rdata", ufp_rdata, ref_line(ufp_addr));
            if (dfp_resp) begin
                check_equal("dfp_addr[4:0]", dfp_addr[4:0], 0);
                mem_delay = 3'd1 + 3'(rand_bits(2));
            end
            if (dfp_resp && dfp_read) begin
                read_count++;
                last_read_addr = dfp_addr;
            end
            if (dfp_resp && dfp_write) begin
                check_equal("dfp_wdata", dfp_wdata, ref_line(dfp_addr));
                write_count++;
                last_write_addr = dfp_addr;
                if (in_flush && flushed[line_index(dfp_addr)]) begin
                    stop_run($sformatf("line %h was written back twice in one flush", dfp_addr));
                end
                if (in_flush) flushed[line_index(dfp_addr)] = 1'b1;
            end
        end
    end

    initial begin
        int          n;
        int          r0;
        int          w0;
        int          tag;
        int          set;
        logic [31:0] a;
        logic [31:0] pred;
        ufp_addr    = '0;
        ufp_read    = 1'b0;
        ufp_write   = 1'b0;
        ufp_wdata   = '0;
        flush       = 1'b0;
        mem_delay   = 3'd1;
        lfsr        = 16'd4922;
        errors      = 0;
        read_count  = 0;
        write_count = 0;
        in_flush    = 1'b0;
        written     = '0;
        flushed     = '0;
        for (int i = 0; i < 64; i++) begin
            mem_i.mem[i] = fill_line(line_addr(i / 8, i % 8));
        end
        n = 0;
        while (!rst_n) begin
            n++;
            if (n > 20) stop_run("reset was never released");
            @(posedge clk);
        end
        #1;

        a  = line_addr(1, 0);            // cold miss, then a hit
        r0 = read_count;
        access(1'b0, a, '0);
        check_equal("dfp_read count", read_count - r0, 1);
        check_equal("dfp_addr", last_read_addr, a);
        r0 = read_count;
        access(1'b0, a, '0);
        check_equal("dfp_read count", read_count - r0, 0);

        a = line_addr(2, 1);
        access(1'b1, a, rand_line());
        access(1'b0, a, '0);

        // five tags in set 5, the last one evicts
        for (int t = 0; t < 5; t++) begin
            w0 = write_count;
            access(1'b1, line_addr(t, 5), rand_line());
        end
        check_equal("dfp_write count", write_count - w0, 1);
        r0 = read_count;
        access(1'b0, last_write_addr, '0);
        check_equal("dfp_read count", read_count - r0, 1);

        m_tree  = '0;                    // set 7 is untouched so far
        m_valid = '0;
        for (int t = 0; t < 4; t++) begin
            access(1'b1, line_addr(t, 7), rand_line());
            track(t);
        end
        access(1'b0, line_addr(2, 7), '0);
        track(2);
        access(1'b0, line_addr(0, 7), '0);
        track(0);
        access(1'b0, line_addr(3, 7), '0);
        track(3);
        pred = line_addr(m_tag[tree_victim(m_tree)], 7);
        w0   = write_count;
        access(1'b1, line_addr(4, 7), rand_line());
        track(4);
        check_equal("dfp_write count", write_count - w0, 1);
        check_equal("evicted dfp_addr", last_write_addr, pred);
        r0 = read_count;
        access(1'b0, pred, '0);
        check_equal("dfp_read count", read_count - r0, 1);
        check_equal("dfp_addr", last_read_addr, pred);

        run_flush();
        for (int i = 0; i < 64; i++) begin
            if (written[i]) begin
                r0 = read_count;
                access(1'b0, line_addr(i / 8, i % 8), '0);
                check_equal("dfp_read count", read_count - r0, 1);
            end
        end

        for (int i = 0; i < 300; i++) begin
            tag = rand_bits(3);
            set = 2 + rand_bits(1);
            a   = line_addr(tag, set);
            if (rand_bits(1)) access(1'b1, a, rand_line());
            else              access(1'b0, a, '0);
        end

        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

// ==== compile.f ====
+incdir+common
common/l2_pkg.sv
common/l2_array_if.sv
logic/flush_walker.sv
l2cache/l2_plru.sv
l2cache/l2_ways.sv
l2cache/l2_ctrl.sv
l2cache/l2_top.sv
tb/tb_clk_gen.sv
tb/l2_mem_model.sv
tb/l2_tb.sv

// ==== Bender.yml ====
package:
  name: l2cache

sources:
  - include_dirs:
      - common
    files:
      - common/l2_pkg.sv
      - common/l2_array_if.sv
      - logic/flush_walker.sv
      - l2cache/l2_plru.sv
      - l2cache/l2_ways.sv
      - l2cache/l2_ctrl.sv
      - l2cache/l2_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clk_gen.sv
      - tb/l2_mem_model.sv
      - tb/l2_tb.sv
